/* Bender.yml */
package:
  name: dbg_hub

export_include_dirs:
  - source

sources:
  - source/dbg_chain_pkg.sv
  - source/dbg_target_pkg.sv
  - source/dbg_bus_module.sv
  - source/dbg_cpu_module.sv
  - source/dbg_hub.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_dbg_hub.sv

/* all.f */
+incdir+source
+incdir+verification
source/dbg_chain_pkg.sv
source/dbg_target_pkg.sv
source/dbg_bus_module.sv
source/dbg_cpu_module.sv
source/dbg_hub.sv
verification/tb_dbg_hub.sv

/* source/dbg_bus_module.sv */
// Bus debug module
// Turns write and read commands from the chain into single word transfers
// on the memory bus, then shifts read data back out on capture
// Inhibit stays high for the whole transfer so the hub keeps this module selected

`timescale 1ns/1ps
`default_nettype none

`include "dbg_config.svh"

module dbg_bus_module
  import dbg_chain_pkg::*;
  import dbg_target_pkg::*;
(
  input  wire logic      tck_i,
  input  wire logic      tlr_i,
  input  wire logic      capture_dr_i,
  input  wire logic      shift_dr_i,
  input  wire logic      update_dr_i,
  input  wire logic      module_select_i,
  input  wire dbg_cmd_t  cmd_i,
  output      logic      module_tdo_o,
  output      logic      top_inhibit_o,
  output      bus_req_t  bus_req_o,
  input  wire logic      bus_ack_i,
  input  wire bus_data_t bus_rdata_i
);

  bus_state_e state;
  bus_data_t  rdata;
  logic       req_write;
  bus_addr_t  req_addr;
  bus_data_t  req_wdata;
  logic       bus_cmd;
  logic       start;
  logic       busy;

  logic [`DBG_BUS_OUT_LEN-1:0] out_reg;

  ////////////////////
  // Command decode
  ////////////////////

  assign bus_cmd = (cmd_i.opcode == OP_BUS_WRITE) || (cmd_i.opcode == OP_BUS_READ);
  // Commands during a pending transfer fall through
  assign start   = update_dr_i && module_select_i && bus_cmd && (state == BUS_IDLE);
  assign busy    = (state == BUS_WAIT);

  ////////////////////
  // Transfer FSM
  ////////////////////

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      state <= BUS_IDLE;
      rdata <= '0;
    end else begin
      case (state)
        BUS_IDLE: begin
          if (start) begin
            state <= BUS_WAIT;
          end
        end
        BUS_WAIT: begin
          // Back-pressure just keeps us here
          if (bus_ack_i) begin
            state <= BUS_IDLE;
            if (!req_write) begin
              rdata <= bus_rdata_i;
            end
          end
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  // Request payload, only meaningful while valid
  always_ff @(posedge tck_i) begin
    if (start) begin
      req_write <= (cmd_i.opcode == OP_BUS_WRITE);
      req_addr  <= cmd_i.addr;
      req_wdata <= cmd_i.data;
    end
  end

  always_comb begin
    bus_req_o.valid = busy;
    bus_req_o.write = req_write;
    bus_req_o.addr  = req_addr;
    bus_req_o.wdata = req_wdata;
  end

  assign top_inhibit_o = busy;

  ////////////////////
  // Readout
  ////////////////////

  // Read data above busy flag, LSB goes out first
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      out_reg <= '0;
    end else if (module_select_i && capture_dr_i) begin
      out_reg <= {rdata, busy};
    end else if (module_select_i && shift_dr_i) begin
      out_reg <= {1'b0, out_reg[`DBG_BUS_OUT_LEN-1:1]};
    end
  end

  assign module_tdo_o = out_reg[0];

endmodule

`default_nettype wire

/* source/dbg_chain_pkg.sv */
// Types for the JTAG side of the debug hub
// Opcodes, module numbers and the command word sliced from the chain
// Import into any module that decodes chain commands

`default_nettype none

`include "dbg_config.svh"

package dbg_chain_pkg;

  // Module number held in the select register
  typedef logic [`DBG_MODULE_ID_LEN-1:0] dbg_module_id_t;

  ////////////////////
  // Opcodes
  ////////////////////

  typedef enum logic [`DBG_OPCODE_LEN-1:0] {
    OP_NOP          = 4'd0,
    OP_BUS_WRITE    = 4'd1,
    OP_BUS_READ     = 4'd2,
    OP_CPU_STALL    = 4'd3,
    OP_CPU_CLEAR_BP = 4'd4
  } dbg_opcode_e;

  ////////////////////
  // Command word
  ////////////////////

  // Bits 51..0 of the chain, opcode first
  // Data field doubles as stall value or breakpoint clear mask
  typedef struct packed {
    dbg_opcode_e                opcode;
    logic [`DBG_ADDR_WIDTH-1:0] addr;
    logic [`DBG_DATA_WIDTH-1:0] data;
  } dbg_cmd_t;

endpackage

`default_nettype wire

/* source/dbg_config.svh */
// Shared constants for the JTAG debug hub
// Include wherever chain geometry, bus widths or module numbers are needed
// Types built from these live in the two packages

`ifndef DBG_CONFIG_SVH
`define DBG_CONFIG_SVH

////////////////////
// Chain geometry
////////////////////

// Shared shift register, MSB is the last bit shifted in
`define DBG_DATAREG_LEN   53
// Select flag sits in the MSB
`define DBG_SELECT_BIT    52
// Module command payload below the select flag
`define DBG_CMD_LEN       52
`define DBG_MODULE_ID_LEN 2
`define DBG_OPCODE_LEN    4

////////////////////
// Target widths
////////////////////

`define DBG_ADDR_WIDTH 16
`define DBG_DATA_WIDTH 32
`define DBG_NUM_CORES  4

// Readout registers, bus data above busy bit, cpu flags above stalls
`define DBG_BUS_OUT_LEN (`DBG_DATA_WIDTH + 1)
`define DBG_CPU_OUT_LEN (2 * `DBG_NUM_CORES)

// Module numbers, 2 and 3 reserved
`define DBG_BUS_MODULE 2'd0
`define DBG_CPU_MODULE 2'd1

`endif

/* source/dbg_cpu_module.sv */
// CPU debug module
// Holds one stall bit and one sticky breakpoint flag per core
// A breakpoint from a core stalls it until the debugger releases it
// Status readout puts the breakpoint flags above the stall bits

`timescale 1ns/1ps
`default_nettype none

`include "dbg_config.svh"

module dbg_cpu_module
  import dbg_chain_pkg::*;
  import dbg_target_pkg::*;
(
  input  wire logic       tck_i,
  input  wire logic       tlr_i,
  input  wire logic       capture_dr_i,
  input  wire logic       shift_dr_i,
  input  wire logic       update_dr_i,
  input  wire logic       module_select_i,
  input  wire dbg_cmd_t   cmd_i,
  output      logic       module_tdo_o,
  input  wire core_mask_t cpu_bp_i,
  output      core_mask_t cpu_stall_o
);

  core_mask_t stall;
  core_mask_t bp_flags;
  core_mask_t stall_nxt;
  core_mask_t bp_nxt;
  core_mask_t cmd_mask;
  logic       cmd_en;

  logic [`DBG_CPU_OUT_LEN-1:0] out_reg;

  assign cmd_en   = update_dr_i && module_select_i;
  // Low data bits address the cores
  assign cmd_mask = cmd_i.data[`DBG_NUM_CORES-1:0];

  ////////////////////
  // Stall and breakpoints
  ////////////////////

  always_comb begin
    stall_nxt = stall;
    bp_nxt    = bp_flags;
    if (cmd_en && (cmd_i.opcode == OP_CPU_STALL)) begin
      stall_nxt = cmd_mask;
    end
    if (cmd_en && (cmd_i.opcode == OP_CPU_CLEAR_BP)) begin
      bp_nxt = bp_flags & ~cmd_mask;
    end
    // Breakpoint wins over a same-cycle release or clear
    stall_nxt = stall_nxt | cpu_bp_i;
    bp_nxt    = bp_nxt | cpu_bp_i;
  end

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      stall    <= '0;
      bp_flags <= '0;
    end else begin
      stall    <= stall_nxt;
      bp_flags <= bp_nxt;
    end
  end

  assign cpu_stall_o = stall;

  ////////////////////
  // Readout
  ////////////////////

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      out_reg <= '0;
    end else if (module_select_i && capture_dr_i) begin
      out_reg <= {bp_flags, stall};
    end else if (module_select_i && shift_dr_i) begin
      out_reg <= {1'b0, out_reg[`DBG_CPU_OUT_LEN-1:1]};
    end
  end

  assign module_tdo_o = out_reg[0];

endmodule

`default_nettype wire

/* source/dbg_hub.sv */
// JTAG debug hub, top level
// Shifts the shared data register, latches the module number from select
// commands and hands module commands to the bus and CPU modules
// Everything runs on the TAP clock; the TAP controller sits outside

`timescale 1ns/1ps
`default_nettype none

`include "dbg_config.svh"

module dbg_hub
  import dbg_chain_pkg::*;
  import dbg_target_pkg::*;
(
  input  wire logic       tck_i,
  input  wire logic       tlr_i,
  input  wire logic       tdi_i,
  input  wire logic       shift_dr_i,
  input  wire logic       capture_dr_i,
  input  wire logic       update_dr_i,
  input  wire logic       debug_select_i,
  output      logic       tdo_o,
  output      bus_req_t   bus_req_o,
  input  wire logic       bus_ack_i,
  input  wire bus_data_t  bus_rdata_i,
  input  wire core_mask_t cpu_bp_i,
  output      core_mask_t cpu_stall_o
);

  logic [`DBG_DATAREG_LEN-1:0] shift_reg;
  dbg_module_id_t              module_id;
  dbg_module_id_t              module_id_in;
  dbg_cmd_t                    cmd;
  logic                        select_cmd;
  logic                        bus_inhibit;
  logic [1:0]                  module_sel;
  logic                        dr_capture;
  logic                        dr_shift;
  logic                        cmd_update;
  logic                        tdo_bus;
  logic                        tdo_cpu;

  ////////////////////
  // Chain decode
  ////////////////////

  assign select_cmd   = shift_reg[`DBG_SELECT_BIT];
  assign module_id_in = shift_reg[`DBG_SELECT_BIT-1 -: `DBG_MODULE_ID_LEN];
  assign cmd          = dbg_cmd_t'(shift_reg[`DBG_CMD_LEN-1:0]);

  // Strobes only count while our instruction is in the IR
  assign dr_capture = capture_dr_i && debug_select_i;
  assign dr_shift   = shift_dr_i && debug_select_i;
  // Update without the select flag is a module command
  assign cmd_update = update_dr_i && debug_select_i && !select_cmd;

  // New bits enter at the MSB, register shifts right
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      shift_reg <= '0;
    end else if (dr_shift) begin
      shift_reg <= {tdi_i, shift_reg[`DBG_DATAREG_LEN-1:1]};
    end
  end

  ////////////////////
  // Module select
  ////////////////////

  // Select dropped while a bus transfer is outstanding
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      module_id <= `DBG_BUS_MODULE;
    end else if (update_dr_i && debug_select_i && select_cmd && !bus_inhibit) begin
      module_id <= module_id_in;
    end
  end

  // One-hot, reserved numbers select nothing
  always_comb begin
    module_sel    = 2'b00;
    module_sel[0] = (module_id == `DBG_BUS_MODULE);
    module_sel[1] = (module_id == `DBG_CPU_MODULE);
  end

  ////////////////////
  // Debug modules
  ////////////////////

  dbg_bus_module u_bus (
    .tck_i           (tck_i),
    .tlr_i           (tlr_i),
    .capture_dr_i    (dr_capture),
    .shift_dr_i      (dr_shift),
    .update_dr_i     (cmd_update),
    .module_select_i (module_sel[0]),
    .cmd_i           (cmd),
    .module_tdo_o    (tdo_bus),
    .top_inhibit_o   (bus_inhibit),
    .bus_req_o       (bus_req_o),
    .bus_ack_i       (bus_ack_i),
    .bus_rdata_i     (bus_rdata_i)
  );

  dbg_cpu_module u_cpu (
    .tck_i           (tck_i),
    .tlr_i           (tlr_i),
    .capture_dr_i    (dr_capture),
    .shift_dr_i      (dr_shift),
    .update_dr_i     (cmd_update),
    .module_select_i (module_sel[1]),
    .cmd_i           (cmd),
    .module_tdo_o    (tdo_cpu),
    .cpu_bp_i        (cpu_bp_i),
    .cpu_stall_o     (cpu_stall_o)
  );

  // tdo mux, low for reserved numbers
  always_comb begin
    case (module_id)
      `DBG_BUS_MODULE: tdo_o = tdo_bus;
      `DBG_CPU_MODULE: tdo_o = tdo_cpu;
      default:         tdo_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/dbg_target_pkg.sv */
// Types for the targets behind the debug hub
// Memory bus words, the bus request bundle and per-core masks
// Import into modules that face the bus or the cores

`default_nettype none

`include "dbg_config.svh"

package dbg_target_pkg;

  typedef logic [`DBG_ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [`DBG_DATA_WIDTH-1:0] bus_data_t;

  // One bit per core
  typedef logic [`DBG_NUM_CORES-1:0] core_mask_t;

  // Request towards memory, held until acknowledged
  typedef struct packed {
    logic      valid;
    logic      write;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  // Bus module transfer FSM
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT
  } bus_state_e;

endpackage

`default_nettype wire

/* verification/tb_dbg_model.svh */
// Reference model for the debug hub testbench
// Included inside the testbench module body
// Holds the memory behind the bus responder, the expected core state
// and builders for 53-bit chain words

`ifndef TB_DBG_MODEL_SVH
`define TB_DBG_MODEL_SVH

// Memory behind the bus, written and read by the responder
logic [`DBG_DATA_WIDTH-1:0] mem_model [0:(1 << `DBG_ADDR_WIDTH)-1];

// Expected core state
logic [`DBG_NUM_CORES-1:0] exp_stall;
logic [`DBG_NUM_CORES-1:0] exp_bp;

// Fill pattern built from every address bit
task automatic fill_memory();
  int          a;
  logic [15:0] la;
  for (a = 0; a < (1 << `DBG_ADDR_WIDTH); a++) begin
    la = a[15:0];
    mem_model[a] = {la ^ 16'hc3a5, ~la};
  end
endtask

////////////////////
// Chain builders
////////////////////

// Select flag in bit 52, module number in bits 51..50
function automatic logic [`DBG_DATAREG_LEN-1:0] select_word(input logic [1:0] id);
  logic [`DBG_DATAREG_LEN-1:0] w;
  w        = '0;
  w[52]    = 1'b1;
  w[51:50] = id;
  return w;
endfunction

// Flag clear, then opcode, address and data
function automatic logic [`DBG_DATAREG_LEN-1:0] command_word(input logic [3:0] opcode,
                                                            input logic [15:0] addr,
                                                            input logic [31:0] data);
  logic [`DBG_DATAREG_LEN-1:0] w;
  w        = '0;
  w[51:48] = opcode;
  w[47:32] = addr;
  w[31:0]  = data;
  return w;
endfunction

`endif

/* verification/tb_dbg_hub.sv */
// Testbench for the JTAG debug hub
// Plays the TAP controller, answers bus requests from a model memory
// and checks bus requests, stall lines and scanned-out status
// Build with all.f, top module tb_dbg_hub

`timescale 1ns/1ps
`default_nettype none

`include "dbg_config.svh"

module tb_dbg_hub
  import dbg_chain_pkg::*;
  import dbg_target_pkg::*;
();

  localparam int CLK_PERIOD     = 8;
  localparam int NUM_PAIRS      = 8;
  // Scans issued by all tests together
  localparam int NUM_CMDS       = 17 + 3 * NUM_PAIRS;
  localparam int CYCLES_PER_CMD = 80;

  logic       tck_i;
  logic       tlr_i;
  logic       tdi_i;
  logic       shift_dr_i;
  logic       capture_dr_i;
  logic       update_dr_i;
  logic       debug_select_i;
  logic       tdo_o;
  bus_req_t   bus_req_o;
  logic       bus_ack_i;
  bus_data_t  bus_rdata_i;
  core_mask_t cpu_bp_i;
  core_mask_t cpu_stall_o;

  integer seed;
  integer ack_seed;
  logic   hold_ack;
  integer ack_count;
  logic [`DBG_DATAREG_LEN-1:0] scan_out;

  `include "tb_dbg_model.svh"

  dbg_hub u_dbg_hub (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .tdi_i          (tdi_i),
    .shift_dr_i     (shift_dr_i),
    .capture_dr_i   (capture_dr_i),
    .update_dr_i    (update_dr_i),
    .debug_select_i (debug_select_i),
    .tdo_o          (tdo_o),
    .bus_req_o      (bus_req_o),
    .bus_ack_i      (bus_ack_i),
    .bus_rdata_i    (bus_rdata_i),
    .cpu_bp_i       (cpu_bp_i),
    .cpu_stall_o    (cpu_stall_o)
  );

  initial begin
    tck_i = 1'b0;
    forever #(CLK_PERIOD / 2) tck_i = ~tck_i;
  end

  initial begin : watchdog
    repeat (NUM_CMDS * CYCLES_PER_CMD) @(posedge tck_i);
    $display("Timeout: tests did not finish within %0d cycles", NUM_CMDS * CYCLES_PER_CMD);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Bus responder
  ////////////////////

  // Acks after 0..3 cycles unless held off
  initial begin : bus_responder
    integer delay;
    bus_ack_i   = 1'b0;
    bus_rdata_i = '0;
    ack_count   = 0;
    ack_seed    = 32'hcceb1ca8;
    forever begin
      @(negedge tck_i);
      if (bus_req_o.valid && !hold_ack) begin
        delay = $unsigned($random(ack_seed)) % 4;
        repeat (delay) @(negedge tck_i);
        while (hold_ack) @(negedge tck_i);
        bus_ack_i = 1'b1;
        if (bus_req_o.write) begin
          mem_model[bus_req_o.addr] = bus_req_o.wdata;
        end else begin
          bus_rdata_i = mem_model[bus_req_o.addr];
        end
        ack_count = ack_count + 1;
        @(negedge tck_i);
        bus_ack_i = 1'b0;
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // Capture, 53 shifts with tdo sampled and an update strobe
  // Starts and ends on a falling edge
  task automatic dr_scan(input logic [`DBG_DATAREG_LEN-1:0] word);
    int i;
    capture_dr_i = 1'b1;
    @(negedge tck_i);
    capture_dr_i = 1'b0;
    for (i = 0; i < `DBG_DATAREG_LEN; i++) begin
      shift_dr_i  = 1'b1;
      tdi_i       = word[i];
      scan_out[i] = tdo_o;
      @(negedge tck_i);
    end
    shift_dr_i  = 1'b0;
    update_dr_i = 1'b1;
    @(negedge tck_i);
    update_dr_i = 1'b0;
  endtask

  task automatic wait_bus_idle();
    int n;
    n = 0;
    while (bus_req_o.valid) begin
      @(negedge tck_i);
      n++;
      if (n > 20) begin
        $display("Bus transfer was never acknowledged");
        $display("Some tests failed");
        $fatal(1, "bus transfer stuck");
      end
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin : tests
    logic [15:0] addrs [0:NUM_PAIRS-1];
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [3:0]  bp_bit;
    integer      acks;
    int          k;
    seed           = 32'hcceb1ca8;
    tlr_i          = 1'b1;
    tdi_i          = 1'b0;
    shift_dr_i     = 1'b0;
    capture_dr_i   = 1'b0;
    update_dr_i    = 1'b0;
    debug_select_i = 1'b0;
    cpu_bp_i       = '0;
    hold_ack       = 1'b0;
    exp_stall      = '0;
    exp_bp         = '0;
    fill_memory();
    repeat (4) @(posedge tck_i);
    @(negedge tck_i);
    tlr_i          = 1'b0;
    debug_select_i = 1'b1;
    @(negedge tck_i);

    // Reset state with the bus module selected
    dr_scan(command_word(OP_NOP, '0, '0));
    check_value("reset readout", 0, scan_out[32:0]);
    check_value("reset valid", 0, bus_req_o.valid);
    check_value("reset stall", 0, cpu_stall_o);

    // Writes, then reads back from the same addresses
    for (k = 0; k < NUM_PAIRS; k++) begin
      addrs[k] = $random(seed);
      data     = $random(seed);
      dr_scan(command_word(OP_BUS_WRITE, addrs[k], data));
      check_value("write valid", 1, bus_req_o.valid);
      check_value("write flag", 1, bus_req_o.write);
      check_value("write addr", addrs[k], bus_req_o.addr);
      check_value("write data", data, bus_req_o.wdata);
      wait_bus_idle();
    end
    for (k = 0; k < NUM_PAIRS; k++) begin
      dr_scan(command_word(OP_BUS_READ, addrs[k], '0));
      check_value("read valid", 1, bus_req_o.valid);
      check_value("read flag", 0, bus_req_o.write);
      check_value("read addr", addrs[k], bus_req_o.addr);
      wait_bus_idle();
      dr_scan(command_word(OP_NOP, '0, '0));
      check_value("read data", {mem_model[addrs[k]], 1'b0}, scan_out[32:0]);
    end

    // Stall mask through the CPU module
    dr_scan(select_word(`DBG_CPU_MODULE));
    mask = $random(seed);
    dr_scan(command_word(OP_CPU_STALL, '0, {28'b0, mask}));
    exp_stall = mask;
    check_value("stall lines", exp_stall, cpu_stall_o);
    dr_scan(command_word(OP_NOP, '0, '0));
    check_value("stall status", {exp_bp, exp_stall}, scan_out[7:0]);

    // One-cycle breakpoint from a random core
    bp_bit   = 4'b0001 << ($unsigned($random(seed)) % 4);
    cpu_bp_i = bp_bit;
    @(negedge tck_i);
    cpu_bp_i  = '0;
    exp_stall = exp_stall | bp_bit;
    exp_bp    = exp_bp | bp_bit;
    check_value("bp stall", exp_stall, cpu_stall_o);
    dr_scan(command_word(OP_NOP, '0, '0));
    check_value("bp status", {exp_bp, exp_stall}, scan_out[7:0]);
    dr_scan(command_word(OP_CPU_CLEAR_BP, '0, {28'b0, bp_bit}));
    exp_bp = exp_bp & ~bp_bit;
    check_value("clear bp stall", exp_stall, cpu_stall_o);
    dr_scan(command_word(OP_NOP, '0, '0));
    check_value("clear bp status", {exp_bp, exp_stall}, scan_out[7:0]);

    // Select during a held transfer gets dropped
    dr_scan(select_word(`DBG_BUS_MODULE));
    hold_ack = 1'b1;
    addr     = $random(seed);
    dr_scan(command_word(OP_BUS_READ, addr, '0));
    check_value("held valid", 1, bus_req_o.valid);
    dr_scan(select_word(`DBG_CPU_MODULE));
    check_value("still pending", 1, bus_req_o.valid);
    // Capture of that scan saw the transfer in flight
    check_value("held busy", 1, scan_out[0]);
    hold_ack = 1'b0;
    wait_bus_idle();
    dr_scan(command_word(OP_NOP, '0, '0));
    check_value("dropped select", {mem_model[addr], 1'b0}, scan_out[32:0]);
    dr_scan(select_word(`DBG_CPU_MODULE));
    dr_scan(command_word(OP_NOP, '0, '0));
    check_value("repeated select", {exp_bp, exp_stall}, scan_out[7:0]);

    // Reserved module gives a quiet tdo and no bus traffic
    dr_scan(select_word(2'd2));
    addr = $random(seed);
    data = $random(seed);
    dr_scan(command_word(OP_NOP, addr, data));
    check_value("reserved tdo", 0, scan_out);
    acks = ack_count;
    dr_scan(command_word(OP_BUS_WRITE, addr, data));
    check_value("reserved write", 0, bus_req_o.valid);
    dr_scan(command_word(OP_BUS_READ, addr, '0));
    check_value("reserved read", 0, bus_req_o.valid);
    repeat (4) @(negedge tck_i);
    check_value("reserved requests", acks, ack_count);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
